/* hw/mfb2axi_pkg.sv */
/*
 * Shared widths and types for the MFB to AXI-Stream converter.
 * Imported by every stage and by the top level.
 */

package mfb2axi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus geometry
    ////////////////////////////////////////////////////////////////////////////

    // Two regions, one eight-byte block each
    localparam int mfb_regions = 2;
    localparam int block_bytes = 8;
    localparam int data_bytes  = mfb_regions * block_bytes;
    localparam int data_width  = data_bytes * 8;
    // End byte position inside one region
    localparam int pos_width   = $clog2(block_bytes);

    ////////////////////////////////////////////////////////////////////////////
    // Data word views
    ////////////////////////////////////////////////////////////////////////////

    // Same bits, seen flat by AXI and per region by MFB
    typedef union packed {
        logic [data_width-1:0]                     flat;
        logic [mfb_regions-1:0][block_bytes*8-1:0] region;
    } mfb_data_u;

    // One MFB word with per-region framing
    typedef struct packed {
        mfb_data_u                            data;
        logic [mfb_regions-1:0]               sof;
        logic [mfb_regions-1:0]               eof;
        // Last valid byte of a region that ends a frame
        logic [mfb_regions-1:0][pos_width-1:0] eof_pos;
    } mfb_word_t;

    // One AXI-Stream beat
    typedef struct packed {
        logic [data_width-1:0] tdata;
        logic [data_bytes-1:0] tkeep;
        logic                  tlast;
    } axi_beat_t;

endpackage

/* hw/mfb_rx_stage.sv */
/*
 * MFB input register with a one-word skid buffer.
 * Keeps rx_dst_rdy a flop output while the splitter stalls.
 */

`timescale 1ns/1ps

module mfb_rx_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    // MFB receive side
    input  mfb2axi_pkg::mfb_word_t rx,
    input  logic                   rx_src_rdy,
    output logic                   rx_dst_rdy,
    // Toward the splitter
    output mfb2axi_pkg::mfb_word_t word,
    output logic                   word_vld,
    input  logic                   word_rdy
);

    import mfb2axi_pkg::*;

    // Extra word caught after downstream ready drops
    mfb_word_t skid_q;
    // High while the skid register is free
    logic      skid_empty;
    logic      rx_fire;
    // Output register may take a new word
    logic      out_free;

    assign rx_fire    = rx_src_rdy && rx_dst_rdy;
    assign out_free   = !word_vld || word_rdy;
    // Flop output, low only while the skid holds a word
    assign rx_dst_rdy = skid_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_vld   <= 1'b0;
            skid_empty <= 1'b1;
        end else if (out_free) begin
            // Drain the skid first, rx is held off meanwhile
            if (!skid_empty) begin
                word_vld   <= 1'b1;
                skid_empty <= 1'b1;
            end else begin
                word_vld <= rx_fire;
            end
        end else if (rx_fire) begin
            // Output stalled, park the in-flight word
            skid_empty <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (out_free) begin
            word <= skid_empty ? rx : skid_q;
        end else if (rx_fire) begin
            skid_q <= rx;
        end
    end

endmodule

/* hw/mfb_frame_split.sv */
/*
 * Frame tracker and word splitter between MFB words and AXI beats.
 * Builds tkeep per region and sends a word holding the end of one frame
 * and the start of the next as two beats, one per frame.
 */

`timescale 1ns/1ps

module mfb_frame_split (
    input  logic                   clk,
    input  logic                   rst_n,
    // From the rx stage
    input  mfb2axi_pkg::mfb_word_t word,
    input  logic                   word_vld,
    output logic                   word_rdy,
    // Toward the tx stage
    output mfb2axi_pkg::axi_beat_t beat,
    output logic                   beat_vld,
    input  logic                   beat_rdy
);

    import mfb2axi_pkg::*;

    // Inside a frame across word boundaries
    logic                                   in_frame;
    // Second half of a split word is due
    logic                                   pend;
    // Per-region decode of the current word
    logic [mfb_regions-1:0]                 r_act;
    logic [mfb_regions-1:0]                 r_end;
    logic [mfb_regions-1:0][block_bytes-1:0] r_keep;
    logic                                   frame_after0;
    logic                                   split;
    logic                                   nxt_frame;
    logic                                   any_act;
    logic                                   last;
    mfb_data_u                              data;
    // Beat register may load
    logic                                   out_en;

    // Bytes 0 up to pos of a region
    function automatic logic [block_bytes-1:0] end_mask(input logic [pos_width-1:0] pos);
        logic [block_bytes-1:0] mask;
        for (int i = 0; i < block_bytes; i++) begin
            mask[i] = (i <= int'(pos));
        end
        return mask;
    endfunction

    assign out_en   = !beat_vld || beat_rdy;
    // Held off while the first fragment of a split goes out
    assign word_rdy = out_en && !split;

    ////////////////////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Region 0 is spent once the first fragment has left
        r_act[0]     = !pend && (in_frame || word.sof[0]);
        r_end[0]     = r_act[0] && word.eof[0];
        frame_after0 = r_act[0] && !word.eof[0];
        // Frame ends in region 0, next one starts in region 1
        split        = r_end[0] && word.sof[1];
        r_act[1]     = !split && (frame_after0 || word.sof[1]);
        r_end[1]     = r_act[1] && word.eof[1];
        nxt_frame    = r_act[1] ? !word.eof[1] : frame_after0;
        any_act      = |r_act;
        last         = r_end[1] || (r_end[0] && !r_act[1]);

        for (int r = 0; r < mfb_regions; r++) begin
            if (!r_act[r]) begin
                // Lanes outside the frame carry nothing
                r_keep[r]      = '0;
                data.region[r] = '0;
            end else begin
                r_keep[r]      = r_end[r] ? end_mask(word.eof_pos[r]) : '1;
                data.region[r] = word.data.region[r];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame state and beat valid
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_vld <= 1'b0;
            in_frame <= 1'b0;
            pend     <= 1'b0;
        end else if (out_en) begin
            // Idle words give no beat
            beat_vld <= word_vld && any_act;
            if (word_vld) begin
                in_frame <= nxt_frame;
                pend     <= split;
            end
        end
    end

    // Beat payload, lanes unchanged
    always_ff @(posedge clk) begin
        if (out_en) begin
            beat.tdata <= data.flat;
            beat.tkeep <= r_keep;
            beat.tlast <= last;
        end
    end

endmodule

/* hw/axi_tx_stage.sv */
/*
 * AXI-Stream output register.
 * Holds the beat stable under tready back-pressure, no bubble on refill.
 */

`timescale 1ns/1ps

module axi_tx_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    // From the splitter
    input  mfb2axi_pkg::axi_beat_t beat,
    input  logic                   beat_vld,
    output logic                   beat_rdy,
    // AXI transmit side
    output mfb2axi_pkg::axi_beat_t tx,
    output logic                   tx_tvalid,
    input  logic                   tx_tready
);

    import mfb2axi_pkg::*;

    // Beat currently presented on the bus
    axi_beat_t tx_q;
    logic      tx_fire;

    assign tx_fire = tx_tvalid && tx_tready;
    // Empty register or beat leaving this cycle
    assign beat_rdy = !tx_tvalid || tx_tready;
    assign tx       = tx_q;

    ////////////////////////////////////////////////////////////////////////////
    // Valid flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_tvalid <= 1'b0;
        end else if (beat_rdy) begin
            tx_tvalid <= beat_vld;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beat register
    ////////////////////////////////////////////////////////////////////////////

    // Load when empty or when the held beat transfers
    always_ff @(posedge clk) begin
        if (beat_vld && (!tx_tvalid || tx_fire)) begin
            tx_q <= beat;
        end
    end

endmodule

/* hw/mfb2axi_top.sv */
/*
 * MFB to AXI-Stream converter top level.
 * Chains rx register, frame splitter and tx register, three cycles deep.
 */

`timescale 1ns/1ps

module mfb2axi_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // MFB receive side
    input  mfb2axi_pkg::mfb_word_t rx,
    input  logic                   rx_src_rdy,
    output logic                   rx_dst_rdy,
    // AXI transmit side
    output mfb2axi_pkg::axi_beat_t tx,
    output logic                   tx_tvalid,
    input  logic                   tx_tready
);

    import mfb2axi_pkg::*;

    // Rx stage to splitter
    mfb_word_t word;
    logic      word_vld;
    logic      word_rdy;
    // Splitter to tx stage
    axi_beat_t beat;
    logic      beat_vld;
    logic      beat_rdy;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////////

    // Registered MFB input with skid
    mfb_rx_stage rx_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .word       (word),
        .word_vld   (word_vld),
        .word_rdy   (word_rdy)
    );

    // Frame tracking and split
    mfb_frame_split frame_split_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .word     (word),
        .word_vld (word_vld),
        .word_rdy (word_rdy),
        .beat     (beat),
        .beat_vld (beat_vld),
        .beat_rdy (beat_rdy)
    );

    // AXI output register
    axi_tx_stage tx_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat      (beat),
        .beat_vld  (beat_vld),
        .beat_rdy  (beat_rdy),
        .tx        (tx),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready)
    );

endmodule

/* dv/mfb2axi_sva.sv */
/*
 * Protocol checker bound into the converter top level.
 * Covers AXI hold under back-pressure, reset values and empty-pipe latency.
 */

`timescale 1ns/1ps

module mfb2axi_sva (
    input logic                   clk,
    input logic                   rst_n,
    input mfb2axi_pkg::mfb_word_t rx,
    input logic                   rx_src_rdy,
    input logic                   rx_dst_rdy,
    input logic                   word_vld,
    input logic                   beat_vld,
    input mfb2axi_pkg::axi_beat_t tx,
    input logic                   tx_tvalid,
    input logic                   tx_tready
);

    import mfb2axi_pkg::*;

    // Failed property count
    int   fail_cnt = 0;
    // Frame start entering an empty pipeline
    logic lone_start;

    assign lone_start = rx_src_rdy && rx_dst_rdy && (|rx.sof)
                     && !word_vld && !beat_vld && !tx_tvalid;

    ////////////////////////////////////////////////////////////////////////////
    // AXI side
    ////////////////////////////////////////////////////////////////////////////

    // Beat frozen while the sink stalls
    hold_p: assert property (@(posedge clk) disable iff (!rst_n)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx))
    else begin
        fail_cnt++;
        $error("AXI beat changed or vanished while tready was low");
    end

    // A valid beat carries at least one byte
    keep_p: assert property (@(posedge clk) disable iff (!rst_n)
        tx_tvalid |-> tx.tkeep != '0)
    else begin
        fail_cnt++;
        $error("AXI beat with tvalid high has an empty tkeep");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset and latency
    ////////////////////////////////////////////////////////////////////////////

    reset_p: assert property (@(posedge clk)
        $rose(rst_n) |-> !tx_tvalid && rx_dst_rdy)
    else begin
        fail_cnt++;
        $error("Wrong tvalid or dst_rdy right after reset");
    end

    // First beat exactly three cycles after the transfer
    latency_p: assert property (@(posedge clk) disable iff (!rst_n)
        $past(lone_start, 3) && $past(tx_tready, 2) && $past(tx_tready, 1) |-> tx_tvalid)
    else begin
        fail_cnt++;
        $error("Lone frame did not reach the AXI side after three cycles");
    end

    early_p: assert property (@(posedge clk) disable iff (!rst_n)
        $past(lone_start, 1) || $past(lone_start, 2) |-> !tx_tvalid)
    else begin
        fail_cnt++;
        $error("Lone frame reached the AXI side too early");
    end

endmodule

bind mfb2axi_top mfb2axi_sva sva_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_src_rdy (rx_src_rdy),
    .rx_dst_rdy (rx_dst_rdy),
    .word_vld   (word_vld),
    .beat_vld   (beat_vld),
    .tx         (tx),
    .tx_tvalid  (tx_tvalid),
    .tx_tready  (tx_tready)
);

/* dv/tb_mfb2axi.sv */
/*
 * Testbench of the MFB to AXI-Stream converter.
 * Drives directed and random frames and checks bytes, tkeep and tlast on the AXI side.
 */

`timescale 1ns/1ps

module tb_mfb2axi;

    import mfb2axi_pkg::*;

    // One MFB region as laid out by the generator
    typedef struct packed {
        logic [block_bytes*8-1:0] data;
        logic                     idle;
        logic                     sof;
        logic                     eof;
        logic [pos_width-1:0]     pos;
    } region_t;

    logic      clk;
    logic      rst_n;
    mfb_word_t rx;
    logic      rx_src_rdy;
    logic      rx_dst_rdy;
    axi_beat_t tx;
    logic      tx_tvalid;
    logic      tx_tready;

    // Regions not yet packed into words
    region_t               regions[$];
    // Reference model with bytes and lengths per frame and keep and last per beat
    logic [7:0]            exp_bytes[$];
    int                    exp_len[$];
    logic [data_bytes-1:0] exp_keep[$];
    logic                  exp_last[$];

    int          beat_errors;
    int          leftover;
    int          sva_fails;
    bit          timed_out;
    bit          bp_en;
    int          gap_pct;
    int          rx_len;
    int unsigned wait_limit = 2000;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    mfb2axi_top mfb2axi_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx         (tx),
        .tx_tvalid  (tx_tvalid),
        .tx_tready  (tx_tready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Frame generation and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Lanes a region gives to its frame
    function automatic logic [block_bytes-1:0] region_keep(input region_t r);
        if (r.idle) begin
            return '0;
        end else if (r.eof) begin
            return 8'hff >> (7 - r.pos);
        end
        return '1;
    endfunction

    task automatic add_frame(input int len, input bit gap);
        region_t r;
        int      left;
        // Optional idle region ahead of the frame
        if (gap) begin
            r      = '0;
            r.idle = 1'b1;
            r.data = {$urandom, $urandom};
            regions.push_back(r);
        end
        exp_len.push_back(len);
        left = len;
        while (left > 0) begin
            r     = '0;
            r.sof = (left == len);
            r.eof = (left <= block_bytes);
            r.pos = r.eof ? pos_width'(left - 1) : '0;
            for (int i = 0; i < block_bytes; i++) begin
                r.data[8*i +: 8] = 8'($urandom);
                if (i < left) exp_bytes.push_back(r.data[8*i +: 8]);
            end
            regions.push_back(r);
            left -= block_bytes;
        end
    endtask

    // Beats a word must give
    // Two beats when one frame ends in region 0 and the next starts in region 1
    task automatic expect_beats(input region_t r0, input region_t r1);
        if (!r0.idle && r0.eof && !r1.idle) begin
            exp_keep.push_back({8'h00, region_keep(r0)});
            exp_last.push_back(1'b1);
            exp_keep.push_back({region_keep(r1), 8'h00});
            exp_last.push_back(r1.eof);
        end else if (!r0.idle || !r1.idle) begin
            exp_keep.push_back({region_keep(r1), region_keep(r0)});
            exp_last.push_back(r1.idle ? r0.eof : r1.eof);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // MFB driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_word(input mfb_word_t w);
        bit          accepted;
        int unsigned t;
        if ($urandom_range(99) < gap_pct) begin
            rx_src_rdy = 1'b0;
            repeat ($urandom_range(1, 3)) @(negedge clk);
        end
        rx         = w;
        rx_src_rdy = 1'b1;
        accepted   = 1'b0;
        t          = 0;
        while (!accepted && !timed_out) begin
            // dst_rdy now is what the next rising edge sees
            accepted = rx_dst_rdy;
            @(negedge clk);
            t++;
            if (!accepted && t >= wait_limit) begin
                $display("Timeout: rx_dst_rdy stayed low for %0d cycles", t);
                timed_out = 1'b1;
            end
        end
        rx_src_rdy = 1'b0;
    endtask

    // Pack pending regions two by two and send them
    task automatic flush_words();
        region_t   r0;
        region_t   r1;
        mfb_word_t w;
        if (regions.size() % 2 != 0) begin
            r0      = '0;
            r0.idle = 1'b1;
            regions.push_back(r0);
        end
        while (regions.size() > 0 && !timed_out) begin
            r0 = regions.pop_front();
            r1 = regions.pop_front();
            expect_beats(r0, r1);
            w.data.region[0] = r0.data;
            w.data.region[1] = r1.data;
            w.sof            = {r1.sof, r0.sof};
            w.eof            = {r1.eof, r0.eof};
            w.eof_pos[0]     = r0.pos;
            w.eof_pos[1]     = r1.pos;
            send_word(w);
        end
    endtask

    task automatic drain();
        int unsigned t;
        t = 0;
        while (exp_keep.size() > 0 && !timed_out) begin
            @(negedge clk);
            t++;
            if (t >= wait_limit) begin
                $display("Timeout: %0d expected beats never came out", exp_keep.size());
                timed_out = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI sink and monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_beat();
        logic [data_bytes-1:0] keep_e;
        logic                  last_e;
        logic [7:0]            byte_e;
        int                    len_e;
        if (exp_keep.size() == 0) begin
            $display("AXI beat came out with no beat left to expect");
            beat_errors++;
        end else begin
            keep_e = exp_keep.pop_front();
            last_e = exp_last.pop_front();
            assert (tx.tkeep == keep_e) else begin
                $display("ERR tx.tkeep exp=%h act=%h", keep_e, tx.tkeep);
                beat_errors++;
            end
            assert (tx.tlast == last_e) else begin
                $display("ERR tx.tlast exp=%h act=%h", last_e, tx.tlast);
                beat_errors++;
            end
        end
        // Collect kept bytes in lane order
        for (int i = 0; i < data_bytes; i++) begin
            if (tx.tkeep[i]) begin
                rx_len++;
                if (exp_bytes.size() == 0) begin
                    $display("AXI beat carried a byte after all expected bytes were used");
                    beat_errors++;
                end else begin
                    byte_e = exp_bytes.pop_front();
                    assert (tx.tdata[8*i +: 8] === byte_e) else begin
                        $display("ERR tx.tdata[%0d] exp=%h act=%h",
                                 i, byte_e, tx.tdata[8*i +: 8]);
                        beat_errors++;
                    end
                end
            end
        end
        if (tx.tlast) begin
            len_e = (exp_len.size() > 0) ? exp_len.pop_front() : -1;
            assert (rx_len == len_e) else begin
                $display("ERR frame_len exp=%h act=%h", len_e, rx_len);
                beat_errors++;
            end
            rx_len = 0;
        end
    endtask

    // tready is set first, so the beat seen here transfers on the next edge
    initial begin : axi_sink
        tx_tready   = 1'b1;
        rx_len      = 0;
        beat_errors = 0;
        forever begin
            @(negedge clk);
            tx_tready = bp_en ? ($urandom_range(99) < 70) : 1'b1;
            if (rst_n && tx_tvalid && tx_tready) check_beat();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        void'($urandom(32'hab4237da));
        rst_n      = 1'b0;
        rx         = '0;
        rx_src_rdy = 1'b0;
        leftover   = 0;
        timed_out  = 1'b0;
        bp_en      = 1'b0;
        gap_pct    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Lone short frame into an empty pipe
        add_frame(5, 1'b0);
        flush_words();
        drain();

        // Two split words and a short frame in region 1 of the second
        add_frame(3, 1'b0);
        add_frame(11, 1'b0);
        add_frame(6, 1'b0);
        add_frame(2, 1'b0);
        flush_words();
        drain();

        // Random lengths, gaps and back-pressure
        bp_en   = 1'b1;
        gap_pct = 25;
        for (int n = 0; n < 150 && !timed_out; n++) begin
            add_frame($urandom_range(1, 40), $urandom_range(2) == 0);
            if (regions.size() >= 8 && regions.size() % 2 == 0) flush_words();
        end
        flush_words();
        drain();

        assert (exp_bytes.size() == 0 && exp_len.size() == 0) else begin
            $display("Frames were still waiting for output at the end of the run");
            leftover++;
        end
        sva_fails = mfb2axi_top_inst.sva_inst.fail_cnt;
        $display("Errors: beat %0d, leftover %0d, sva %0d, timeout %0d",
                 beat_errors, leftover, sva_fails, timed_out);
        if (beat_errors == 0 && leftover == 0 && sva_fails == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
hw/mfb2axi_pkg.sv
hw/mfb_rx_stage.sv
hw/mfb_frame_split.sv
hw/axi_tx_stage.sv
hw/mfb2axi_top.sv
dv/mfb2axi_sva.sv
dv/tb_mfb2axi.sv

/* Makefile */
# Verilator build and run of the MFB to AXI-Stream converter testbench

VERILATOR ?= verilator
TOP       ?= tb_mfb2axi
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status follows the search for the pass message
run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
